// File: logic/div_config.svh
// Divider configuration
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// operand width, RV32
`define DIV_XLEN 32

// restoring iterations done in one stage
`define DIV_ITERS 4

// one quotient bit per iteration, so XLEN / ITERS stages
`define DIV_STAGES (`DIV_XLEN / `DIV_ITERS)

// slots in the consumer's result buffer
`define DIV_CREDITS 4

// request tag width
`define DIV_TAG_W 4

// prep + stages + fix-up, counted from the accepting cycle
`define DIV_LATENCY (`DIV_STAGES + 2)

`endif

// File: logic/div_pkg.sv
// Divider types
`default_nettype none

`include "div_config.svh"

package div_pkg;

  // low bits of funct3 for the M-extension divide ops
  typedef enum logic [1:0] {
    OP_DIV  = 2'b00,
    OP_DIVU = 2'b01,
    OP_REM  = 2'b10,
    OP_REMU = 2'b11
  } div_op_e;

  typedef struct packed {
    div_op_e                op;
    logic [`DIV_XLEN-1:0]   dividend;
    logic [`DIV_XLEN-1:0]   divisor;
    logic [`DIV_TAG_W-1:0]  tag;
  } div_req_t;

  // item carried down the stage chain
  typedef struct packed {
    logic                   valid;
    logic [`DIV_TAG_W-1:0]  tag;
    logic                   want_rem;    // remainder, not quotient
    logic                   neg_quot;    // flip quotient sign at the end
    logic                   neg_rem;     // flip remainder sign at the end
    logic [`DIV_XLEN-1:0]   rem_acc;     // partial remainder
    // dividend bits shift out at the top, quotient bits shift in at the bottom
    logic [`DIV_XLEN-1:0]   quot_acc;
    logic [`DIV_XLEN-1:0]   divisor_mag;
  } div_work_t;

  typedef struct packed {
    logic [`DIV_TAG_W-1:0]  tag;
    logic [`DIV_XLEN-1:0]   result;
  } div_rsp_t;

endpackage

`default_nettype wire

// File: logic/div_credit_counter.sv
// Result credit counter
`timescale 1ns/1ns
`default_nettype none

`include "div_config.svh"

module div_credit_counter (
  input  logic clk,
  input  logic rst,
  input  logic req_valid,
  input  logic credit_return,
  output logic in_ready,
  output logic accept
);

  localparam int CNT_W = $clog2(`DIV_CREDITS + 1);

  logic [CNT_W-1:0] credit_cnt;  // free slots in the consumer buffer

  // ready only while a slot is still free for the result
  assign in_ready = (credit_cnt != '0);
  assign accept   = req_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt <= CNT_W'(`DIV_CREDITS);
    end else begin
      case ({accept, credit_return})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;  // spent on a new request
        2'b01:   credit_cnt <= credit_cnt + 1'b1;  // slot freed downstream
        default: credit_cnt <= credit_cnt;         // none, or both cancel out
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/div_operand_prep.sv
// Divider operand preparation
`timescale 1ns/1ns
`default_nettype none

`include "div_config.svh"

module div_operand_prep (
  input  logic                clk,
  input  logic                rst,
  input  logic                accept,
  input  div_pkg::div_req_t   req,
  output div_pkg::div_work_t  work
);

  logic                 is_signed;
  logic                 dvd_neg;
  logic                 dvs_neg;
  logic                 dvs_zero;
  logic [`DIV_XLEN-1:0] dvd_mag;
  logic [`DIV_XLEN-1:0] dvs_mag;
  div_pkg::div_work_t   work_d;

  assign is_signed = (req.op == div_pkg::OP_DIV) || (req.op == div_pkg::OP_REM);

  // sign bits only count for div and rem
  assign dvd_neg  = is_signed && req.dividend[`DIV_XLEN-1];
  assign dvs_neg  = is_signed && req.divisor[`DIV_XLEN-1];
  assign dvs_zero = (req.divisor == '0);

  // two's complement magnitude; the most negative value maps onto itself,
  // which is its correct unsigned magnitude
  assign dvd_mag = dvd_neg ? (~req.dividend + 1'b1) : req.dividend;
  assign dvs_mag = dvs_neg ? (~req.divisor + 1'b1) : req.divisor;

  always_comb begin
    work_d             = '0;
    work_d.valid       = accept;
    work_d.tag         = req.tag;
    work_d.want_rem    = (req.op == div_pkg::OP_REM) || (req.op == div_pkg::OP_REMU);
    // x / 0 stays all ones, so no flip there
    work_d.neg_quot    = (dvd_neg ^ dvs_neg) && !dvs_zero;
    work_d.neg_rem     = dvd_neg;  // remainder follows the dividend
    work_d.rem_acc     = '0;
    work_d.quot_acc    = dvd_mag;
    work_d.divisor_mag = dvs_mag;
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      work <= work_d;
    end
    work.valid <= accept;
    if (rst) begin
      work.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: logic/div_stage.sv
// Restoring division stage
`timescale 1ns/1ns
`default_nettype none

`include "div_config.svh"

module div_stage #(
  parameter int ITERS = `DIV_ITERS
) (
  input  logic                clk,
  input  logic                rst,
  input  div_pkg::div_work_t  work_in,
  output div_pkg::div_work_t  work_out
);

  div_pkg::div_work_t   work_nxt;
  logic [`DIV_XLEN:0]   trial;     // shifted remainder, one bit wider
  logic [`DIV_XLEN:0]   diff;
  logic                 quot_bit;

  // ITERS unrolled steps, one quotient bit each
  always_comb begin
    work_nxt = work_in;
    trial    = '0;
    diff     = '0;
    quot_bit = 1'b0;
    for (int i = 0; i < ITERS; i++) begin
      // bring down the next dividend bit
      trial = {work_nxt.rem_acc, work_nxt.quot_acc[`DIV_XLEN-1]};
      diff  = trial - {1'b0, work_nxt.divisor_mag};
      if (trial >= {1'b0, work_nxt.divisor_mag}) begin
        quot_bit         = 1'b1;
        work_nxt.rem_acc = diff[`DIV_XLEN-1:0];  // fits, keep the difference
      end else begin
        quot_bit         = 1'b0;
        work_nxt.rem_acc = trial[`DIV_XLEN-1:0];  // restore
      end
      work_nxt.quot_acc = {work_nxt.quot_acc[`DIV_XLEN-2:0], quot_bit};
    end
  end

  // payload just follows, only valid is cleared
  always_ff @(posedge clk) begin
    work_out <= work_nxt;
    if (rst) begin
      work_out.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: logic/div_result_fixup.sv
// Divider result fix-up
`timescale 1ns/1ns
`default_nettype none

`include "div_config.svh"

module div_result_fixup (
  input  logic                clk,
  input  logic                rst,
  input  div_pkg::div_work_t  work,
  output logic                rsp_valid,
  output div_pkg::div_rsp_t   rsp
);

  logic [`DIV_XLEN-1:0] quot;
  logic [`DIV_XLEN-1:0] rem;
  logic [`DIV_XLEN-1:0] result;

  // unsigned quotient and remainder with their signs restored
  assign quot = work.neg_quot ? (~work.quot_acc + 1'b1) : work.quot_acc;
  assign rem  = work.neg_rem ? (~work.rem_acc + 1'b1) : work.rem_acc;

  assign result = work.want_rem ? rem : quot;

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= work.valid;
    end
  end

  // response payload, held between results
  always_ff @(posedge clk) begin
    if (work.valid) begin
      rsp.tag    <= work.tag;
      rsp.result <= result;
    end
  end

endmodule

`default_nettype wire

// File: logic/div_unit.sv
// Pipelined divide unit
`timescale 1ns/1ns
`default_nettype none

`include "div_config.svh"

module div_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_valid,
  input  div_pkg::div_req_t  req,
  output logic               in_ready,
  output logic               rsp_valid,
  output div_pkg::div_rsp_t  rsp,
  input  logic               credit_return
);

  logic accept;

  // link 0 leaves prep, link DIV_STAGES feeds the fix-up
  div_pkg::div_work_t work_link [0:`DIV_STAGES];

  div_credit_counter credit_inst (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .credit_return (credit_return),
    .in_ready      (in_ready),
    .accept        (accept)
  );

  div_operand_prep prep_inst (
    .clk    (clk),
    .rst    (rst),
    .accept (accept),
    .req    (req),
    .work   (work_link[0])
  );

  for (genvar g = 0; g < `DIV_STAGES; g++) begin : gen_stage
    div_stage #(
      .ITERS (`DIV_ITERS)
    ) stage_inst (
      .clk      (clk),
      .rst      (rst),
      .work_in  (work_link[g]),
      .work_out (work_link[g+1])
    );
  end

  div_result_fixup fixup_inst (
    .clk       (clk),
    .rst       (rst),
    .work      (work_link[`DIV_STAGES]),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

endmodule

`default_nettype wire

// File: test/div_unit_checker.sv
// Divider result checker
`timescale 1ns/1ns
`default_nettype none

`include "div_config.svh"

module div_unit_checker #(
  parameter int NUM_TESTS = 1,
  parameter int NAME_W    = 128
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  input  div_pkg::div_req_t     req,
  input  logic                  in_ready,
  input  logic                  rsp_valid,
  input  div_pkg::div_rsp_t     rsp,
  input  logic                  credit_return,
  input  logic [NAME_W-1:0]     test_name  [NUM_TESTS],
  input  logic [`DIV_XLEN-1:0]  exp_result [NUM_TESTS],
  output int                    result_count,
  output int                    pass_count,
  output int                    fail_count,
  output int                    other_errors,
  output logic                  saw_stall
);

  longint                 cycle;
  int                     credit_model;  // free buffer slots per the credit rule
  int                     returned;
  logic                   rst_q;
  longint                 accept_cycle_q [$];
  logic [`DIV_TAG_W-1:0]  accept_tag_q [$];
  longint                 acc_cycle;
  logic [`DIV_TAG_W-1:0]  acc_tag;
  logic                   bad;

  initial begin
    cycle        = 0;
    credit_model = `DIV_CREDITS;
    returned     = 0;
    rst_q        = 1'b0;
    result_count = 0;
    pass_count   = 0;
    fail_count   = 0;
    other_errors = 0;
    saw_stall    = 1'b0;
  end

  task automatic check_response();
    if (accept_cycle_q.size() == 0 || result_count >= NUM_TESTS) begin
      $display("unexpected response with tag %0d at %0t ns", rsp.tag, $time);
      other_errors++;
    end else begin
      acc_cycle = accept_cycle_q.pop_front();
      acc_tag   = accept_tag_q.pop_front();
      bad       = 1'b0;
      if (rsp.tag !== acc_tag) begin
        $display("[FAIL] %0t ns rsp.tag: got %0d, expected %0d", $time, rsp.tag, acc_tag);
        bad = 1'b1;
      end
      if (rsp.result !== exp_result[result_count]) begin
        $display("[FAIL] %0t ns rsp.result: got 0x%08h, expected 0x%08h",
                 $time, rsp.result, exp_result[result_count]);
        bad = 1'b1;
      end
      if (cycle - acc_cycle != `DIV_LATENCY) begin
        $display("result of test %0d came %0d cycles after acceptance instead of %0d",
                 result_count, cycle - acc_cycle, `DIV_LATENCY);
        bad = 1'b1;
      end
      if (bad) begin
        $display("test %0d %0s failed", result_count, test_name[result_count]);
        fail_count++;
      end else begin
        $display("[PASS] test %0d %0s: 0x%08h", result_count, test_name[result_count],
                 rsp.result);
        pass_count++;
      end
      result_count++;
      if (result_count > returned + `DIV_CREDITS) begin
        $display("results outnumber returned credits plus buffer size at %0t ns", $time);
        other_errors++;
      end
    end
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (rst) begin
      credit_model = `DIV_CREDITS;
      accept_cycle_q.delete();
      accept_tag_q.delete();
    end else begin
      if (rst_q) begin  // first cycle out of reset
        if (rsp_valid !== 1'b0) begin
          $display("[FAIL] %0t ns rsp_valid: got %b, expected 0", $time, rsp_valid);
          other_errors++;
        end
        if (in_ready !== 1'b1) begin
          $display("[FAIL] %0t ns in_ready: got %b, expected 1", $time, in_ready);
          other_errors++;
        end
      end else if (in_ready !== (credit_model > 0)) begin
        $display("[FAIL] %0t ns in_ready: got %b, expected %b",
                 $time, in_ready, credit_model > 0);
        other_errors++;
      end
      if (!in_ready) begin
        saw_stall = 1'b1;
      end
      if (req_valid && in_ready) begin
        accept_cycle_q.push_back(cycle);
        accept_tag_q.push_back(req.tag);
      end
      if (rsp_valid) begin
        check_response();
      end
      credit_model = credit_model + (credit_return ? 1 : 0) - ((req_valid && in_ready) ? 1 : 0);
      if (credit_return) begin
        returned++;
      end
    end
    rst_q = rst;
  end

endmodule

`default_nettype wire

// File: test/div_unit_tb.sv
// Divider testbench
`timescale 1ns/1ns
`default_nettype none

`include "div_config.svh"

module div_unit_tb;

  localparam int NUM_TESTS      = 18;
  localparam int CLK_HALF       = 2;    // 4 ns period
  localparam int RESET_CYCLES   = 5;
  localparam int DRIVE_DELAY    = 1;    // after the rising edge
  localparam int READY_TIMEOUT  = 100;
  localparam int RESULT_TIMEOUT = 100;
  localparam int NAME_W         = 8 * 16;

  logic               clk;
  logic               rst;
  logic               req_valid;
  logic               in_ready;
  logic               rsp_valid;
  logic               credit_return;
  div_pkg::div_req_t  req;
  div_pkg::div_rsp_t  rsp;

  // stimulus table with expected values worked out by hand
  logic [NAME_W-1:0]     test_name  [NUM_TESTS];
  div_pkg::div_op_e      test_op    [NUM_TESTS];
  logic [`DIV_XLEN-1:0]  test_dvd   [NUM_TESTS];
  logic [`DIV_XLEN-1:0]  test_dvs   [NUM_TESTS];
  logic [`DIV_XLEN-1:0]  exp_result [NUM_TESTS];
  int                    table_size;

  int     results_seen;
  integer seed;
  logic   timed_out;
  int     result_count;
  int     pass_count;
  int     fail_count;
  int     other_errors;
  logic   saw_stall;

  div_unit div_unit_inst (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req           (req),
    .in_ready      (in_ready),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp),
    .credit_return (credit_return)
  );

  div_unit_checker #(
    .NUM_TESTS (NUM_TESTS),
    .NAME_W    (NAME_W)
  ) checker_inst (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req           (req),
    .in_ready      (in_ready),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp),
    .credit_return (credit_return),
    .test_name     (test_name),
    .exp_result    (exp_result),
    .result_count  (result_count),
    .pass_count    (pass_count),
    .fail_count    (fail_count),
    .other_errors  (other_errors),
    .saw_stall     (saw_stall)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // results the consumer has received so far
  always @(posedge clk) begin
    if (rst) begin
      results_seen <= 0;
    end else if (rsp_valid) begin
      results_seen <= results_seen + 1;
    end
  end

  task automatic add_test(input logic [NAME_W-1:0] name, input div_pkg::div_op_e op,
                          input logic [`DIV_XLEN-1:0] dvd, input logic [`DIV_XLEN-1:0] dvs,
                          input logic [`DIV_XLEN-1:0] expected);
    test_name[table_size]  = name;
    test_op[table_size]    = op;
    test_dvd[table_size]   = dvd;
    test_dvs[table_size]   = dvs;
    exp_result[table_size] = expected;
    table_size++;
  endtask

  task automatic load_table();
    table_size = 0;
    add_test("divu_basic", div_pkg::OP_DIVU, 32'd100, 32'd7, 32'd14);
    add_test("remu_basic", div_pkg::OP_REMU, 32'd100, 32'd7, 32'd2);
    add_test("divu_small", div_pkg::OP_DIVU, 32'd5, 32'd9, 32'd0);
    add_test("remu_small", div_pkg::OP_REMU, 32'd5, 32'd9, 32'd5);
    // 20 and 6 in all four sign combinations
    add_test("div_pp", div_pkg::OP_DIV, 32'd20, 32'd6, 32'd3);
    add_test("div_np", div_pkg::OP_DIV, 32'hFFFF_FFEC, 32'd6, 32'hFFFF_FFFD);
    add_test("div_pn", div_pkg::OP_DIV, 32'd20, 32'hFFFF_FFFA, 32'hFFFF_FFFD);
    add_test("div_nn", div_pkg::OP_DIV, 32'hFFFF_FFEC, 32'hFFFF_FFFA, 32'd3);
    add_test("rem_pp", div_pkg::OP_REM, 32'd20, 32'd6, 32'd2);
    add_test("rem_np", div_pkg::OP_REM, 32'hFFFF_FFEC, 32'd6, 32'hFFFF_FFFE);
    add_test("rem_pn", div_pkg::OP_REM, 32'd20, 32'hFFFF_FFFA, 32'd2);
    add_test("rem_nn", div_pkg::OP_REM, 32'hFFFF_FFEC, 32'hFFFF_FFFA, 32'hFFFF_FFFE);
    add_test("div_by_zero", div_pkg::OP_DIV, 32'hFFFF_FFEC, 32'd0, 32'hFFFF_FFFF);
    add_test("divu_by_zero", div_pkg::OP_DIVU, 32'd1234, 32'd0, 32'hFFFF_FFFF);
    add_test("rem_by_zero", div_pkg::OP_REM, 32'hFFFF_FFEC, 32'd0, 32'hFFFF_FFEC);
    add_test("remu_by_zero", div_pkg::OP_REMU, 32'd1234, 32'd0, 32'd1234);
    add_test("div_overflow", div_pkg::OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
    add_test("rem_overflow", div_pkg::OP_REM, 32'h8000_0000, 32'hFFFF_FFFF, 32'd0);
  endtask

  // holds the request until an edge with in_ready high takes it
  task automatic issue_request(input int idx);
    int waited;
    waited        = 0;
    req.op        = test_op[idx];
    req.dividend  = test_dvd[idx];
    req.divisor   = test_dvs[idx];
    req.tag       = `DIV_TAG_W'(idx);  // wraps past 15
    req_valid     = 1'b1;
    while (!in_ready && waited < READY_TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
    end
    if (!in_ready) begin
      $display("timeout: in_ready stayed low for %0d cycles before test %0d", waited, idx);
      timed_out = 1'b1;
    end else begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
    req_valid = 1'b0;
  endtask

  task automatic issue_all();
    for (int i = 0; i < table_size; i++) begin
      if (!timed_out) begin
        issue_request(i);
      end
    end
  endtask

  // one credit per result after 0 to 6 idle cycles
  task automatic return_credits();
    int waited;
    int delay;
    for (int n = 0; n < table_size && !timed_out; n++) begin
      waited = 0;
      while (results_seen <= n && waited < RESULT_TIMEOUT && !timed_out) begin
        @(posedge clk);
        #DRIVE_DELAY;
        waited++;
      end
      if (results_seen <= n) begin
        if (!timed_out) begin
          $display("timeout: no result %0d within %0d cycles", n, RESULT_TIMEOUT);
        end
        timed_out = 1'b1;
      end else begin
        delay = $random(seed) % 7;
        if (delay < 0) begin
          delay = -delay;
        end
        repeat (delay) begin
          @(posedge clk);
          #DRIVE_DELAY;
        end
        credit_return = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        credit_return = 1'b0;
      end
    end
  endtask

  initial begin
    rst           = 1'b1;
    req_valid     = 1'b0;
    req           = '0;
    credit_return = 1'b0;
    seed          = 66;
    timed_out     = 1'b0;
    load_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    fork
      issue_all();
      return_credits();
    join
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    $display("tests: %0d expected, %0d returned, %0d passed, %0d failed, %0d other errors",
             table_size, result_count, pass_count, fail_count, other_errors);
    if (timed_out || fail_count != 0 || other_errors != 0 || result_count != table_size ||
        !saw_stall) begin
      if (result_count != table_size) begin
        $display("missing results: only %0d of %0d arrived", result_count, table_size);
      end
      if (!saw_stall) begin
        $display("in_ready never fell, back-pressure was not exercised");
      end
      $display("RESULT: FAIL");
    end else begin
      $display("RESULT: PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/div_pkg.sv
logic/div_credit_counter.sv
logic/div_operand_prep.sv
logic/div_stage.sv
logic/div_result_fixup.sv
logic/div_unit.sv
test/div_unit_checker.sv
test/div_unit_tb.sv

// File: Bender.yml
package:
  name: div_unit

export_include_dirs:
  - logic

sources:
  - files:
      - logic/div_pkg.sv
      - logic/div_credit_counter.sv
      - logic/div_operand_prep.sv
      - logic/div_stage.sv
      - logic/div_result_fixup.sv
      - logic/div_unit.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/div_unit_checker.sv
      - test/div_unit_tb.sv
